// ==== source/spritePkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared widths, sizes and types of the sprite instruction path.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package spritePkg;

	//////////////////////////////////////////////////////////////////////
	// widths and sizes
	//////////////////////////////////////////////////////////////////////
	localparam int wordWidth        = 32;    // instruction and data words.
	localparam int opcodeWidth      = 4;     // low nibble of the first word.
	localparam int registerWidth    = 14;    // register field of an instruction.
	localparam int spriteIndexWidth = 5;     // selects one of the sprites.
	localparam int memAddressWidth  = 14;    // sprite memory address.
	localparam int colorWidth       = 9;     // rgb, 3 bits per channel.

	localparam int spriteCount = 32;         // position and offset registers.
	localparam int memoryDepth = 16384;      // words of sprite memory.

	//////////////////////////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////////////////////////
	typedef logic [wordWidth-1:0]        wordT;          // raw instruction or data word.
	typedef logic [registerWidth-1:0]    registerFieldT; // decoded register field.
	typedef logic [spriteIndexWidth-1:0] spriteIndexT;   // sprite number.
	typedef logic [memAddressWidth-1:0]  memAddressT;    // memory address, also an offset.
	typedef logic [colorWidth-1:0]       colorT;         // {r, g, b}.

	// codes 4 to 15 are illegal and never leave the decoder.
	typedef enum logic [opcodeWidth-1:0] {
		setPosition   = 4'd0,    // x/y word into a position register.
		writeMemory   = 4'd1,    // color into sprite memory.
		setOffset     = 4'd2,    // memory offset of a sprite.
		setBackground = 4'd3     // screen background color.
	} opcodeT;

	typedef enum logic [1:0] {
		idle    = 2'd0,          // waiting for a decoded instruction.
		execute = 2'd1           // one write enable is pulsed.
	} controlStateT;

endpackage

`default_nettype wire

// ==== source/decodedInstructionIf.sv ====
//////////////////////////////////////////////////////////////////////
// decoded instruction, decoder to control unit.
//////////////////////////////////////////////////////////////////////
`default_nettype none

interface decodedInstructionIf;

	logic                     valid;     // one-cycle pulse per instruction.
	spritePkg::opcodeT        opcode;    // only meaningful while valid.
	spritePkg::registerFieldT register;  // sprite number or memory address.
	spritePkg::wordT          data;      // second instruction word.

	// driven by the decoder.
	modport source (
		output valid,
		output opcode,
		output register,
		output data
	);

	// read by the control unit.
	modport sink (
		input valid,
		input opcode,
		input register,
		input data
	);

endinterface

`default_nettype wire

// ==== source/instructionDecoder.sv ====
//////////////////////////////////////////////////////////////////////
// instruction decoder, accepts a two-word instruction and splits it.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module instructionDecoder (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   strobe,    // host presents an instruction.
	input  wire                   ready,     // control unit can take one.
	input  wire spritePkg::wordT  wordA,     // opcode and register bits.
	input  wire spritePkg::wordT  wordB,     // data word.
	decodedInstructionIf.source   decoded
);

	logic                     legal;         // opcode is one of the four.
	logic                     accept;        // instruction taken this edge.
	spritePkg::registerFieldT fieldSelect;   // register field before the flop.

	//////////////////////////////////////////////////////////////////////
	// field selection
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		legal       = 1'b1;
		fieldSelect = '0;
		case (wordA[3:0])
			spritePkg::setPosition,
			spritePkg::setOffset: begin
				// sprite number sits in bits 8 to 4, upper bits ignored.
				fieldSelect = spritePkg::registerFieldT'(wordA[8:4]);
			end
			spritePkg::writeMemory: begin
				fieldSelect = wordA[13:0];          // full memory address.
			end
			spritePkg::setBackground: begin
				fieldSelect = '0;                   // single register, no index.
			end
			default: begin
				legal = 1'b0;                       // dropped without effect.
			end
		endcase
	end

	assign accept = strobe && ready && legal;   // strobes while busy are lost.

	//////////////////////////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			decoded.valid <= 1'b0;
		end else begin
			decoded.valid <= accept;                // high for exactly one cycle.
		end
	end

	// payload only loads on an accepted instruction.
	always_ff @(posedge clk) begin
		if (accept) begin
			decoded.opcode   <= spritePkg::opcodeT'(wordA[3:0]);
			decoded.register <= fieldSelect;
			decoded.data     <= wordB;
		end
	end

endmodule

`default_nettype wire

// ==== source/controlUnit.sv ====
//////////////////////////////////////////////////////////////////////
// control unit, executes one decoded instruction and drives ready.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module controlUnit (
	input  wire                    clk,
	input  wire                    reset,
	decodedInstructionIf.sink      decoded,
	output logic                   ready,            // decoder may accept.
	output logic                   writePosition,    // position register write.
	output logic                   writeOffset,      // offset register write.
	output logic                   writeBackground,  // background register write.
	output logic                   writeMemory,      // sprite memory write.
	output spritePkg::spriteIndexT writeIndex,
	output spritePkg::memAddressT  writeAddress,
	output spritePkg::wordT        writeData
);

	spritePkg::controlStateT  state;
	logic                     settle;        // cycle after execute, still busy.
	spritePkg::opcodeT        heldOpcode;    // latched instruction.
	spritePkg::registerFieldT heldRegister;
	spritePkg::wordT          heldData;

	//////////////////////////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= spritePkg::idle;
			settle <= 1'b0;
		end else begin
			settle <= (state == spritePkg::execute);  // memory write lands first.
			case (state)
				spritePkg::idle:    if (decoded.valid) state <= spritePkg::execute;
				spritePkg::execute: state <= spritePkg::idle;  // always a single cycle.
				default:            state <= spritePkg::idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (decoded.valid) begin
			heldOpcode   <= decoded.opcode;
			heldRegister <= decoded.register;
			heldData     <= decoded.data;
		end
	end

	// low from the valid pulse until one cycle past execute.
	assign ready = !decoded.valid && (state == spritePkg::idle) && !settle;

	//////////////////////////////////////////////////////////////////////
	// write enables
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		writePosition   = 1'b0;
		writeOffset     = 1'b0;
		writeBackground = 1'b0;
		writeMemory     = 1'b0;
		if (state == spritePkg::execute) begin
			case (heldOpcode)
				spritePkg::setPosition:   writePosition   = 1'b1;
				spritePkg::setOffset:     writeOffset     = 1'b1;
				spritePkg::setBackground: writeBackground = 1'b1;
				spritePkg::writeMemory:   writeMemory     = 1'b1;
				default:                  writeMemory     = 1'b0;
			endcase
		end
	end

	assign writeIndex   = spritePkg::spriteIndexT'(heldRegister);  // low 5 bits.
	assign writeAddress = heldRegister;                            // same width.
	assign writeData    = heldData;

endmodule

`default_nettype wire

// ==== source/spriteRegisterBank.sv ====
//////////////////////////////////////////////////////////////////////
// sprite position and offset registers, background color register.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module spriteRegisterBank (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        writePosition,
	input  wire                        writeOffset,
	input  wire                        writeBackground,
	input  wire spritePkg::spriteIndexT writeIndex,
	input  wire spritePkg::wordT        writeData,
	input  wire spritePkg::spriteIndexT readIndex,
	output spritePkg::wordT             readPosition,
	output spritePkg::memAddressT       readOffset,
	output spritePkg::colorT            backgroundColor
);

	spritePkg::wordT       positions [spritePkg::spriteCount];  // {x, y} per sprite.
	spritePkg::memAddressT offsets   [spritePkg::spriteCount];  // first memory word.
	spritePkg::colorT      background;

	//////////////////////////////////////////////////////////////////////
	// register writes
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < spritePkg::spriteCount; i++) begin
				positions[i] <= '0;
				offsets[i]   <= '0;
			end
			background <= '0;
		end else begin
			if (writePosition) begin
				positions[writeIndex] <= writeData;    // whole word.
			end
			if (writeOffset) begin
				offsets[writeIndex] <= spritePkg::memAddressT'(writeData);  // low 14 bits.
			end
			if (writeBackground) begin
				background <= spritePkg::colorT'(writeData);  // low 9 bits.
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reads
	//////////////////////////////////////////////////////////////////////
	assign readPosition    = positions[readIndex];   // combinational.
	assign readOffset      = offsets[readIndex];
	assign backgroundColor = background;

endmodule

`default_nettype wire

// ==== source/spriteMemory.sv ====
//////////////////////////////////////////////////////////////////////
// sprite color memory, one write port and one registered read port.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module spriteMemory (
	input  wire                        clk,
	input  wire                        writeMemory,   // one-cycle write pulse.
	input  wire spritePkg::memAddressT writeAddress,
	input  wire spritePkg::wordT       writeData,     // color in the low bits.
	input  wire spritePkg::memAddressT readAddress,
	output spritePkg::colorT           readColor      // one cycle after the address.
);

	spritePkg::colorT colors [spritePkg::memoryDepth];  // contents undefined at start.

	//////////////////////////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (writeMemory) begin
			colors[writeAddress] <= spritePkg::colorT'(writeData);  // low 9 bits.
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////////////////////////
	// registered read, maps to block ram.
	always_ff @(posedge clk) begin
		readColor <= colors[readAddress];
	end

endmodule

`default_nettype wire

// ==== source/videoInstructionUnit.sv ====
//////////////////////////////////////////////////////////////////////
// top level, decoder, control unit, register bank and sprite memory.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module videoInstructionUnit (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         strobe,          // instruction present.
	input  wire spritePkg::wordT        wordA,
	input  wire spritePkg::wordT        wordB,
	output logic                        ready,           // low while executing.
	input  wire spritePkg::spriteIndexT spriteIndex,     // register read select.
	output spritePkg::wordT             spritePosition,
	output spritePkg::memAddressT       spriteOffset,
	output spritePkg::colorT            backgroundColor,
	input  wire spritePkg::memAddressT  pixelAddress,    // memory read address.
	output spritePkg::colorT            pixelColor       // one cycle later.
);

	logic                  writePosition;
	logic                  writeOffset;
	logic                  writeBackground;
	logic                  writeMemory;
	spritePkg::spriteIndexT writeIndex;
	spritePkg::memAddressT writeAddress;
	spritePkg::wordT       writeData;

	decodedInstructionIf decoded ();     // decoder to control unit.

	instructionDecoder decoder (
		.clk     (clk),
		.reset   (reset),
		.strobe  (strobe),
		.ready   (ready),
		.wordA   (wordA),
		.wordB   (wordB),
		.decoded (decoded.source)
	);

	controlUnit control (
		.clk             (clk),
		.reset           (reset),
		.decoded         (decoded.sink),
		.ready           (ready),
		.writePosition   (writePosition),
		.writeOffset     (writeOffset),
		.writeBackground (writeBackground),
		.writeMemory     (writeMemory),
		.writeIndex      (writeIndex),
		.writeAddress    (writeAddress),
		.writeData       (writeData)
	);

	spriteRegisterBank registers (
		.clk             (clk),
		.reset           (reset),
		.writePosition   (writePosition),
		.writeOffset     (writeOffset),
		.writeBackground (writeBackground),
		.writeIndex      (writeIndex),
		.writeData       (writeData),
		.readIndex       (spriteIndex),
		.readPosition    (spritePosition),
		.readOffset      (spriteOffset),
		.backgroundColor (backgroundColor)
	);

	spriteMemory memory (
		.clk          (clk),
		.writeMemory  (writeMemory),
		.writeAddress (writeAddress),
		.writeData    (writeData),
		.readAddress  (pixelAddress),
		.readColor    (pixelColor)
	);

endmodule

`default_nettype wire

// ==== dv/videoInstructionUnit_sva.sv ====
//////////////////////////////////////////////////////////////////////
// control unit assertions on write enables and ready.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module videoInstructionUnitSva (
	input wire                          clk,
	input wire                          reset,
	input wire                          valid,
	input wire                          ready,
	input wire spritePkg::controlStateT state,
	input wire                          writePosition,
	input wire                          writeOffset,
	input wire                          writeBackground,
	input wire                          writeMemory
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [3:0] writes;                  // all write enables.
	int         failureCount = 0;        // failed assertions so far.

	assign writes = {writePosition, writeOffset, writeBackground, writeMemory};

	oneWriteAtATime: assert property (@(posedge clk) disable iff (!reset)
		$onehot0(writes)) else begin
		$error("more than one write enable high");
		failureCount++;
	end

	validThenWrite: assert property (@(posedge clk) disable iff (!reset)
		valid |=> $onehot(writes)) else begin
		$error("valid not followed by one write");
		failureCount++;
	end

	busyInExecute: assert property (@(posedge clk) disable iff (!reset)
		(state == spritePkg::execute) |-> !ready) else begin
		$error("ready high in execute");
		failureCount++;
	end

endmodule

bind controlUnit videoInstructionUnitSva sva (
	.clk             (clk),
	.reset           (reset),
	.valid           (decoded.valid),
	.ready           (ready),
	.state           (state),
	.writePosition   (writePosition),
	.writeOffset     (writeOffset),
	.writeBackground (writeBackground),
	.writeMemory     (writeMemory)
);

`default_nettype wire

// ==== dv/videoInstructionUnitTb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench that runs the tests file through the instruction path.
//////////////////////////////////////////////////////////////////////
`default_nettype none

module videoInstructionUnitTb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk, reset, strobe, ready;
	spritePkg::wordT wordA, wordB, spritePosition;
	spritePkg::spriteIndexT spriteIndex;
	spritePkg::memAddressT spriteOffset, pixelAddress;
	spritePkg::colorT backgroundColor, pixelColor;

	string names[$], kinds[$], ports[$];              // one entry per test.
	spritePkg::wordT wordAs[$], wordBs[$], selects[$], expects[$];
	int errorCount = 0, passCount = 0, failCount = 0;
	int cycleCount = 0, cycleLimit = 0;
	logic [31:0] lcgState = 32'hbe7;
	bit loaded;

	videoInstructionUnit dut (.*);

	always #4 clk = ~clk;                             // 8 ns period.

	// watchdog armed once the tests are loaded.
	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("timeout: ready never returned");
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////
	function automatic spritePkg::wordT nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// read-back value of a write on each port.
	function automatic spritePkg::wordT expectedFor(input string port, input spritePkg::wordT d);
		if (port == "pos") return d;                  // whole word.
		else if (port == "off") return {18'd0, d[13:0]};
		else return {23'd0, d[8:0]};                  // colors keep 9 bits.
	endfunction

	task automatic loadTests(output bit ok);
		int fd;
		string line, name, kind, port;
		spritePkg::wordT a, b, sel, exp;
		fd = $fopen("dv/videoInstructionUnit_tests.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#" &&
				    $sscanf(line, "%s %s %h %h %s %h %h",
				            name, kind, a, b, port, sel, exp) == 7) begin
					names.push_back(name);
					kinds.push_back(kind);
					wordAs.push_back(a);
					wordBs.push_back(b);
					ports.push_back(port);
					selects.push_back(sel);
					expects.push_back(exp);
				end
			end
			$fclose(fd);
			ok = (names.size() > 0);
		end
	endtask

	task automatic waitReady();
		while (!ready) @(negedge clk);                // watchdog ends a stuck run.
	endtask

	task automatic checkPosition(input string name, input spritePkg::wordT exp,
	                             input spritePkg::wordT act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			errorCount++;
		end
	endtask

	task automatic checkOffset(input string name, input spritePkg::memAddressT exp,
	                           input spritePkg::memAddressT act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			errorCount++;
		end
	endtask

	task automatic checkColor(input string name, input spritePkg::colorT exp,
	                          input spritePkg::colorT act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			errorCount++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one test entered and left on a falling edge
	//////////////////////////////////////////////////////////////////////
	task automatic runTest(input int i);
		spritePkg::wordT data, exp;
		int errorsBefore;
		bit dropped;
		errorsBefore = errorCount;
		dropped = 1'b0;
		data = wordBs[i];
		exp = expects[i];
		if (kinds[i] == "random") begin
			data = nextRandom();
			exp = expectedFor(ports[i], data);
		end
		waitReady();
		strobe = 1'b1;
		wordA = wordAs[i];
		wordB = data;
		@(negedge clk);                               // sampled on the edge just passed.
		strobe = 1'b0;
		if (kinds[i] == "illegal") begin
			repeat (4) begin
				@(negedge clk);
				if (!ready) dropped = 1'b1;
			end
			if (dropped) begin
				$display("%s: ready dropped for an illegal opcode", names[i]);
				errorCount++;
			end
		end else begin
			@(negedge clk);                           // unit busy in execute.
			if (ready) begin
				$display("%s: ready stayed high after an accepted instruction", names[i]);
				errorCount++;
			end
			if (kinds[i] == "hold") begin
				strobe = 1'b1;                        // competing instruction.
				wordB = ~data;
				repeat (2) @(negedge clk);
				strobe = 1'b0;
			end
			waitReady();
		end
		spriteIndex = spritePkg::spriteIndexT'(selects[i]);
		pixelAddress = spritePkg::memAddressT'(selects[i]);
		@(negedge clk);                               // memory read lands here.
		if (ports[i] == "pos") checkPosition(names[i], exp, spritePosition);
		else if (ports[i] == "off") checkOffset(names[i], exp[13:0], spriteOffset);
		else if (ports[i] == "pix") checkColor(names[i], exp[8:0], pixelColor);
		else if (ports[i] == "bkg") checkColor(names[i], exp[8:0], backgroundColor);
		else begin
			$display("%s: unknown read port %s", names[i], ports[i]);
			errorCount++;
		end
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("%s: pass", names[i]);
		end else begin
			failCount++;
			$display("%s: fail", names[i]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		clk = 1'b0;
		reset = 1'b0;
		strobe = 1'b0;
		wordA = '0;
		wordB = '0;
		spriteIndex = '0;
		pixelAddress = '0;
		loadTests(loaded);
		if (!loaded) begin
			$display("could not read any test from the tests file");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			cycleLimit = 20 * names.size() + 100;
			repeat (10) @(posedge clk);
			@(negedge clk) reset = 1'b1;
			@(negedge clk);
			foreach (names[i]) runTest(i);
			$display("tests passed: %0d, failed: %0d", passCount, failCount);
			if (failCount == 0 && errorCount == 0 &&
			    dut.control.sva.failureCount == 0) begin
				$display("STATUS: PASS");
			end else begin
				$display("STATUS: FAIL");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== videoInstructionUnit.f ====
source/spritePkg.sv
source/decodedInstructionIf.sv
source/instructionDecoder.sv
source/controlUnit.sv
source/spriteRegisterBank.sv
source/spriteMemory.sv
source/videoInstructionUnit.sv
dv/videoInstructionUnit_sva.sv
dv/videoInstructionUnitTb.sv

// ==== Bender.yml ====
package:
  name: videoInstructionUnit

sources:
  - source/spritePkg.sv
  - source/decodedInstructionIf.sv
  - source/instructionDecoder.sv
  - source/controlUnit.sv
  - source/spriteRegisterBank.sv
  - source/spriteMemory.sv
  - source/videoInstructionUnit.sv
  - target: test
    files:
      - dv/videoInstructionUnit_sva.sv
      - dv/videoInstructionUnitTb.sv

// ==== dv/videoInstructionUnit_tests.txt ====
# name kind wordA wordB port select expected (hex; port is pos, off, pix or bkg)
# kind is write, hold, illegal or random (random draws wordB and works out expected)
posSprite3 write 00000030 00640032 pos 03 00640032
posSprite31 write 000001f0 01df0000 pos 1f 01df0000
posKeep3 write 00000050 12345678 pos 03 00640032
offSprite3 write fff0f032 ffffabcd off 03 00002bcd
offSprite0 write 00000002 00003fff off 00 00003fff
memAddr1 write 00000001 000001ff pix 0001 000001ff
memAddrHigh write 00003ff1 12345f5a pix 3ff1 0000015a
memKeep1 write 00000011 00000007 pix 0001 000001ff
bkgSet write dead0003 fffffe07 bkg 00 00000007
bkgSet2 write 00000003 000001c7 bkg 00 000001c7
illegalOp4 illegal 00000034 ffffffff pos 03 00640032
illegalOpF illegal 0000000f 00000000 bkg 00 000001c7
illegalOp9 illegal 00003ff9 00000000 pix 3ff1 0000015a
holdPos hold 00000070 0badf00d pos 07 0badf00d
holdBkg hold 00000003 00000055 bkg 00 00000055
holdMem hold 00000021 00000123 pix 0021 00000123
rndPos random 00000090 00000000 pos 09 00000000
rndOff random 000000a2 00000000 off 0a 00000000
rndMem random 00000101 00000000 pix 0101 00000000
rndBkg random 00000003 00000000 bkg 00 00000000
